/* Makefile */
all: run

run:
	verilator --binary --timing -f sources.f --top-module keccak_tb -Mdir obj_dir -o keccak_tb_sim
	./obj_dir/keccak_tb_sim

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module keccak_tb

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

/* bench/keccak_clk_gen.sv */
// Testbench clock source
`default_nettype none

module keccak_clk_gen (
  output logic clk_o
);

  // Half of the 10-unit period
  localparam int HALF_PERIOD = 5;

  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

/* bench/keccak_model.svh */
// Keccak-f[200] model and bus tasks
`ifndef KECCAK_MODEL_SVH
`define KECCAK_MODEL_SVH

////////////////////////////////////////
// Reference permutation
////////////////////////////////////////
// Rotate one bit at a time towards higher z
function automatic lane_t rot_lane(lane_t v, int n);
  lane_t r;
  r = v;
  for (int i = 0; i < n; i++) begin
    r = {r[LANE_W-2:0], r[LANE_W-1]};
  end
  return r;
endfunction

// One round, lanes numbered 5y+x
function automatic state_t model_round(state_t s, int rnd);
  lane_t a [25];
  lane_t b [25];
  lane_t c [5];
  lane_t d;
  for (int i = 0; i < 25; i++) begin
    a[i] = s[LANE_W*i +: LANE_W];
  end
  // Theta
  for (int x = 0; x < 5; x++) begin
    c[x] = a[x] ^ a[x+5] ^ a[x+10] ^ a[x+15] ^ a[x+20];
  end
  for (int x = 0; x < 5; x++) begin
    d = c[(x+4)%5] ^ rot_lane(c[(x+1)%5], 1);
    for (int y = 0; y < 5; y++) begin
      a[5*y+x] = a[5*y+x] ^ d;
    end
  end
  // Rho, then pi moves lane (x,y) to (y, 2x+3y)
  for (int x = 0; x < 5; x++) begin
    for (int y = 0; y < 5; y++) begin
      b[5*((2*x+3*y)%5) + y] = rot_lane(a[5*y+x], RHO_OFFSET[5*x+y]);
    end
  end
  // Chi along rows
  for (int y = 0; y < 5; y++) begin
    for (int x = 0; x < 5; x++) begin
      a[5*y+x] = b[5*y+x] ^ (~b[5*y+(x+1)%5] & b[5*y+(x+2)%5]);
    end
  end
  // Iota on lane (0,0)
  a[0] = a[0] ^ ROUND_CONST[rnd];
  for (int i = 0; i < 25; i++) begin
    s[LANE_W*i +: LANE_W] = a[i];
  end
  return s;
endfunction

// All 18 rounds
function automatic state_t model_permute(state_t s);
  state_t t;
  t = s;
  for (int r = 0; r < NUM_ROUNDS; r++) begin
    t = model_round(t, r);
  end
  return t;
endfunction

////////////////////////////////////////
// Wishbone master
////////////////////////////////////////
// Request, wait for ack, release at the next edge
task automatic bus_xfer(input logic we, input word_idx_t idx, input logic [31:0] wdata,
                        output logic [31:0] rdata);
  @(posedge clk);
  wb_cyc   <= 1'b1;
  wb_stb   <= 1'b1;
  wb_we    <= we;
  wb_adr   <= {idx, 2'b00};
  wb_dat_w <= wdata;
  @(negedge clk);
  while (!wb_ack) begin
    @(negedge clk);
  end
  rdata = wb_dat_r;
  // Ack still high here, so the held request is not taken again
  @(posedge clk);
  wb_cyc <= 1'b0;
  wb_stb <= 1'b0;
  wb_we  <= 1'b0;
endtask

task automatic bus_write(input word_idx_t idx, input logic [31:0] data);
  logic [31:0] rd_dummy;
  bus_xfer(1'b1, idx, data, rd_dummy);
endtask

task automatic bus_read(input word_idx_t idx, output logic [31:0] data);
  bus_xfer(1'b0, idx, 32'h0, data);
endtask

// Control word reads until bit 0 drops
task automatic poll_idle(output int busy_reads, output logic [31:0] last);
  busy_reads = 0;
  bus_read(REG_CTRL, last);
  while (last[0]) begin
    busy_reads++;
    bus_read(REG_CTRL, last);
  end
endtask

`endif

/* bench/keccak_tb.sv */
// Keccak-f[200] Wishbone testbench
`default_nettype none

module keccak_tb
  import keccak_pkg::*;
();

  // Edges per bus transfer, drive to release
  localparam int BUS_CYCLES     = 3;
  // Twelve permutations of about 22 transfers each, with margin
  localparam int PERM_COUNT     = 12;
  localparam int PERM_CYCLES    = 22 * BUS_CYCLES;
  localparam int TIMEOUT_CYCLES = 5 * PERM_COUNT * PERM_CYCLES;

  logic        clk;
  logic        arst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [4:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [3:0]  wb_sel;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        busy;
  int          seed;
  int          cycle_cnt   = 0;
  // Negedges seen with busy_o high
  int          busy_total  = 0;
  state_t      st;
  state_t      res;
  logic [31:0] w;

  keccak_clk_gen u_clk_gen (
    .clk_o (clk)
  );

  keccak_wb_top keccak_wb_top_i (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_sel_i (wb_sel),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack),
    .busy_o   (busy)
  );

  `include "keccak_model.svh"

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_state(input string name, input state_t exp, input state_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      fail_run($sformatf("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act));
    end
  endtask

  // Cycle count and timeout
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      fail_run("Timeout: the tests did not finish within the cycle limit");
    end
  end

  always @(negedge clk) begin
    if (busy) begin
      busy_total <= busy_total + 1;
    end
  end

  ////////////////////////////////////////
  // State transfer
  ////////////////////////////////////////
  task automatic random_state(output state_t s);
    logic [32*NUM_WORDS-1:0] raw;
    for (int i = 0; i < NUM_WORDS; i++) begin
      raw[32*i +: 32] = $random(seed);
    end
    s = raw[STATE_W-1:0];
  endtask

  task automatic write_state(input state_t s);
    logic [31:0] junk;
    for (int i = 0; i < NUM_WORDS - 1; i++) begin
      bus_write(word_idx_t'(i), s[32*i +: 32]);
    end
    // Junk above the last lane must be dropped
    junk = $random(seed);
    bus_write(REG_STATE6, {junk[31:LANE_W], s[STATE_W-1 -: LANE_W]});
  endtask

  task automatic read_state(output state_t s);
    logic [31:0] rd;
    for (int i = 0; i < NUM_WORDS - 1; i++) begin
      bus_read(word_idx_t'(i), rd);
      s[32*i +: 32] = rd;
    end
    bus_read(REG_STATE6, rd);
    check_word("word 6 upper bits", 32'h0, {rd[31:LANE_W], {LANE_W{1'b0}}});
    s[STATE_W-1 -: LANE_W] = rd[LANE_W-1:0];
  endtask

  // Start, poll to idle, compare busy window and result
  task automatic run_and_check(input state_t exp, input bit meddle);
    int          t0;
    int          b0;
    int          busy_reads;
    logic [31:0] last;
    logic [31:0] junk;
    state_t      got;
    b0 = busy_total;
    bus_write(REG_CTRL, 32'h1);
    t0 = cycle_cnt;
    if (meddle) begin
      // Both acked, neither may disturb the run
      junk = $random(seed);
      bus_write(REG_STATE2, junk);
      bus_write(REG_CTRL, 32'h1);
      check_bit("busy_o", 1'b1, busy);
    end
    poll_idle(busy_reads, last);
    check_word("ctrl word", 32'h0, last);
    if (busy_reads == 0) begin
      fail_run("Control word did not report busy after a start");
    end
    // Fall after 18 rounds, seen within one more transfer
    if (cycle_cnt - t0 > NUM_ROUNDS + BUS_CYCLES) begin
      fail_run("Control word still reported busy after the last round");
    end
    if (busy_total - b0 != NUM_ROUNDS) begin
      fail_run($sformatf("busy_o was high for %0d cycles instead of %0d",
                         busy_total - b0, NUM_ROUNDS));
    end
    read_state(got);
    check_state("permuted state", exp, got);
  endtask

  // Held read request, ack alternates
  task automatic held_read(input word_idx_t idx, input logic [31:0] exp);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= {idx, 2'b00};
    @(negedge clk);
    check_bit("wb_ack_o", 1'b0, wb_ack);
    for (int i = 0; i < 7; i++) begin
      @(negedge clk);
      check_bit("wb_ack_o", (i % 2 == 0), wb_ack);
      if (wb_ack) begin
        check_word("held read data", exp, wb_dat_r);
      end
    end
    // Release on a high ack
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    seed     = 23858;
    arst_n   = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    wb_sel   = 4'hF;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_bit("wb_ack_o", 1'b0, wb_ack);
    check_bit("busy_o", 1'b0, busy);
    read_state(res);
    check_state("reset state", '0, res);

    // Round trip while idle
    random_state(st);
    write_state(st);
    read_state(res);
    check_state("round trip state", st, res);
    bus_read(REG_CTRL, w);
    check_word("ctrl word", 32'h0, w);

    // Eight permutations, zero state first
    for (int k = 0; k < 8; k++) begin
      if (k == 0) begin
        st = '0;
      end else begin
        random_state(st);
      end
      write_state(st);
      run_and_check(model_permute(st), 1'b0);
    end

    // Writes while running, then a chained run on the result
    random_state(st);
    write_state(st);
    run_and_check(model_permute(st), 1'b1);
    res = model_permute(model_permute(st));
    run_and_check(res, 1'b0);

    held_read(REG_STATE3, res[32*3 +: 32]);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* logic/keccak_decode.sv */
// Wishbone write decoder
`default_nettype none

module keccak_decode
  import keccak_pkg::*;
(
  input  wire         clk_i,
  input  wire         arst_n_i,

  // Bus request
  input  wire         wb_cyc_i,
  input  wire         wb_stb_i,
  input  wire         wb_we_i,
  input  wire  [4:0]  wb_adr_i,
  input  wire  [31:0] wb_dat_i,
  // Registered ack from readback
  input  wire         wb_ack_i,

  keccak_reg_if.decode reg_o
);

  logic      req;
  logic      accept;
  word_idx_t word_idx;
  reg_addr_e reg_addr;

  ////////////////////////////////////////
  // Request qualification
  ////////////////////////////////////////
  assign req = wb_cyc_i & wb_stb_i;

  // First request cycle only, the ack cycle is skipped
  assign accept = req & ~wb_ack_i;

  ////////////////////////////////////////
  // Address map
  ////////////////////////////////////////
  // Byte address, word select in bits 4 to 2
  assign word_idx = wb_adr_i[4:2];
  assign reg_addr = reg_addr_e'(word_idx);

  always_comb begin
    reg_o.wr_en   = 1'b0;
    reg_o.start   = 1'b0;
    reg_o.wr_idx  = word_idx;
    reg_o.wr_data = wb_dat_i;
    if (accept && wb_we_i) begin
      unique case (reg_addr)
        // Control word, only bit 0 has a meaning
        REG_CTRL: reg_o.start = wb_dat_i[0];
        // Any state word
        default:  reg_o.wr_en = 1'b1;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/keccak_engine.sv */
// Permutation state and round control
`default_nettype none

module keccak_engine
  import keccak_pkg::*;
(
  input  wire         clk_i,
  input  wire         arst_n_i,

  // Word writes and start from decode
  keccak_reg_if.engine reg_i,

  // Flat state for readback
  output state_t      state_o,
  output logic        busy_o
);

  box_t       state_q;
  box_t       round_out;
  state_t     wr_flat;
  rnd_t       rnd_q;
  eng_state_e eng_q;
  logic       last_rnd;

  ////////////////////////////////////////
  // Round datapath
  ////////////////////////////////////////
  keccak_round u_round (
    .state_i (state_q),
    .rnd_i   (rnd_q),
    .state_o (round_out)
  );

  // Word write merged into flat state
  always_comb begin
    wr_flat = to_state(state_q);
    if (reg_i.wr_idx == word_idx_t'(NUM_WORDS - 1)) begin
      // Last word, single lane in the low byte
      wr_flat[STATE_W-1 -: LANE_W] = reg_i.wr_data[LANE_W-1:0];
    end else if (reg_i.wr_idx < word_idx_t'(NUM_WORDS - 1)) begin
      wr_flat[32*reg_i.wr_idx +: 32] = reg_i.wr_data;
    end
  end

  assign last_rnd = (rnd_q == rnd_t'(NUM_ROUNDS - 1));

  ////////////////////////////////////////
  // Idle/run FSM
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      eng_q   <= ENG_IDLE;
      rnd_q   <= '0;
      state_q <= '0;
    end else begin
      unique case (eng_q)
        ENG_IDLE: begin
          // Bus access only while idle
          if (reg_i.start) begin
            rnd_q <= '0;
            eng_q <= ENG_RUN;
          end else if (reg_i.wr_en) begin
            state_q <= to_box(wr_flat);
          end
        end
        ENG_RUN: begin
          // One round per clock
          state_q <= round_out;
          rnd_q   <= rnd_q + rnd_t'(1);
          if (last_rnd) begin
            eng_q <= ENG_IDLE;
          end
        end
        default: eng_q <= ENG_IDLE;
      endcase
    end
  end

  assign state_o = to_state(state_q);
  assign busy_o  = (eng_q == ENG_RUN);

endmodule

`default_nettype wire

/* logic/keccak_pkg.sv */
// Keccak-f[200] shared definitions
`default_nettype none

package keccak_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////
  // Lane width fixes the round count at 12 + 2*log2(8)
  localparam int LANE_W     = 8;
  localparam int STATE_W    = 25 * LANE_W;
  localparam int NUM_ROUNDS = 18;
  // Seven bus words, the last one holds a single lane
  localparam int NUM_WORDS  = 7;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////
  typedef logic [LANE_W-1:0]           lane_t;
  // Indexed [x][y][z]
  typedef logic [4:0][4:0][LANE_W-1:0] box_t;
  // Standard order, bit LANE_W*(5y+x)+z
  typedef logic [STATE_W-1:0]          state_t;
  typedef logic [4:0]                  rnd_t;
  // Bus address bits 4 to 2
  typedef logic [2:0]                  word_idx_t;

  typedef enum logic [2:0] {
    REG_STATE0 = 3'd0,
    REG_STATE1 = 3'd1,
    REG_STATE2 = 3'd2,
    REG_STATE3 = 3'd3,
    REG_STATE4 = 3'd4,
    REG_STATE5 = 3'd5,
    REG_STATE6 = 3'd6,
    // Write bit 0 starts, read bit 0 is busy
    REG_CTRL   = 3'd7
  } reg_addr_e;

  typedef enum logic {
    ENG_IDLE,
    ENG_RUN
  } eng_state_e;

  ////////////////////////////////////////
  // Constant tables
  ////////////////////////////////////////
  // Rho offsets mod 8, entry 5*x+y
  localparam int RHO_OFFSET [25] = '{
    0, 4, 3, 1, 2,
    1, 4, 2, 5, 2,
    6, 6, 3, 7, 5,
    4, 7, 1, 5, 0,
    3, 4, 7, 0, 6
  };

  // Low byte of the 64-bit round constants
  localparam lane_t ROUND_CONST [NUM_ROUNDS] = '{
    8'h01, 8'h82, 8'h8A, 8'h00, 8'h8B, 8'h01,
    8'h81, 8'h09, 8'h8A, 8'h88, 8'h09, 8'h0A,
    8'h8B, 8'h8B, 8'h89, 8'h03, 8'h02, 8'h80
  };

  ////////////////////////////////////////
  // Layout conversion
  ////////////////////////////////////////
  // Flat state to lane box
  function automatic box_t to_box(state_t s);
    box_t b;
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        b[x][y] = s[LANE_W*(5*y+x) +: LANE_W];
      end
    end
    return b;
  endfunction

  // Lane box back to flat state
  function automatic state_t to_state(box_t b);
    state_t s;
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        s[LANE_W*(5*y+x) +: LANE_W] = b[x][y];
      end
    end
    return s;
  endfunction

endpackage

`default_nettype wire

/* logic/keccak_readback.sv */
// Wishbone read data and acknowledge
`default_nettype none

module keccak_readback
  import keccak_pkg::*;
(
  input  wire         clk_i,
  input  wire         arst_n_i,
  input  wire         wb_cyc_i,
  input  wire         wb_stb_i,
  input  wire  [4:0]  wb_adr_i,
  input  wire state_t state_i,
  input  wire         busy_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o
);

  logic        req;
  logic        ack_q;
  logic [31:0] rd_word;
  logic [31:0] dat_q;
  word_idx_t   rd_idx;

  assign req    = wb_cyc_i & wb_stb_i;
  assign rd_idx = wb_adr_i[4:2];

  // Read mux
  always_comb begin
    unique case (reg_addr_e'(rd_idx))
      // Busy flag in bit 0
      REG_CTRL:   rd_word = {31'b0, busy_i};
      // Single lane, zero-extended
      REG_STATE6: rd_word = {{(32 - LANE_W){1'b0}}, state_i[STATE_W-1 -: LANE_W]};
      default:    rd_word = state_i[32*rd_idx +: 32];
    endcase
  end

  // Ack alternates under a held strobe
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req & ~ack_q;
    end
  end

  // Capture on accept, valid with ack
  always_ff @(posedge clk_i) begin
    if (req && !ack_q) begin
      dat_q <= rd_word;
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = dat_q;

endmodule

`default_nettype wire

/* logic/keccak_reg_if.sv */
// Register write channel
`default_nettype none

interface keccak_reg_if
  import keccak_pkg::*;
();

  // One-cycle state word write strobe
  logic        wr_en;
  // Target word and its data
  word_idx_t   wr_idx;
  logic [31:0] wr_data;
  // One-cycle permutation start
  logic        start;

  // Bus side
  modport decode (
    output wr_en, wr_idx, wr_data, start
  );

  // Datapath side
  modport engine (
    input  wr_en, wr_idx, wr_data, start
  );

endinterface

`default_nettype wire

/* logic/keccak_round.sv */
// Keccak-f[200] single round
`default_nettype none

module keccak_round
  import keccak_pkg::*;
(
  // Round input, x/y/z box
  input  wire box_t state_i,
  // Current round index
  input  wire rnd_t rnd_i,
  // Round output
  output box_t      state_o
);

  lane_t col_par [5];
  lane_t col_mix [5];
  box_t  theta_d;
  box_t  rho_d;
  box_t  pi_d;
  box_t  chi_d;
  lane_t rc;

  // Rotate lane towards higher z
  function automatic lane_t rotl(lane_t lane, int amt);
    lane_t res;
    if (amt == 0) begin
      res = lane;
    end else begin
      res = (lane << amt) | (lane >> (LANE_W - amt));
    end
    return res;
  endfunction

  ////////////////////////////////////////
  // Theta
  ////////////////////////////////////////
  always_comb begin
    // Column parities over y
    for (int x = 0; x < 5; x++) begin
      col_par[x] = state_i[x][0] ^ state_i[x][1] ^ state_i[x][2]
                 ^ state_i[x][3] ^ state_i[x][4];
    end
    // Left column plus right column shifted by one in z
    for (int x = 0; x < 5; x++) begin
      col_mix[x] = col_par[(x + 4) % 5]
                 ^ rotl(col_par[(x + 1) % 5], 1);
    end
    for (int x = 0; x < 5; x++) begin
      for (int y = 0; y < 5; y++) begin
        theta_d[x][y] = state_i[x][y] ^ col_mix[x];
      end
    end
  end

  ////////////////////////////////////////
  // Rho and pi
  ////////////////////////////////////////
  always_comb begin
    // Per-lane rotation
    for (int x = 0; x < 5; x++) begin
      for (int y = 0; y < 5; y++) begin
        rho_d[x][y] = rotl(theta_d[x][y], RHO_OFFSET[5*x + y]);
      end
    end
    // Lane (x,y) from lane (x+3y, x)
    for (int x = 0; x < 5; x++) begin
      for (int y = 0; y < 5; y++) begin
        pi_d[x][y] = rho_d[(x + 3*y) % 5][x];
      end
    end
  end

  ////////////////////////////////////////
  // Chi and iota
  ////////////////////////////////////////
  always_comb begin
    // Only nonlinear step, along rows
    for (int x = 0; x < 5; x++) begin
      for (int y = 0; y < 5; y++) begin
        chi_d[x][y] = pi_d[x][y]
                    ^ (~pi_d[(x + 1) % 5][y] & pi_d[(x + 2) % 5][y]);
      end
    end
  end

  // Constant lookup, zero past the last round
  assign rc = (rnd_i < rnd_t'(NUM_ROUNDS)) ? ROUND_CONST[rnd_i] : '0;

  always_comb begin
    state_o       = chi_d;
    // Lane (0,0) only
    state_o[0][0] = chi_d[0][0] ^ rc;
  end

endmodule

`default_nettype wire

/* logic/keccak_wb_top.sv */
// Keccak-f[200] Wishbone slave
`default_nettype none

module keccak_wb_top
  import keccak_pkg::*;
(
  input  wire         clk_i,
  input  wire         arst_n_i,

  // Wishbone classic slave
  input  wire         wb_cyc_i,
  input  wire         wb_stb_i,
  input  wire         wb_we_i,
  input  wire  [4:0]  wb_adr_i,
  input  wire  [31:0] wb_dat_i,
  // Lint waiver: byte selects not decoded, every write is a full word
  input  wire  [3:0]  wb_sel_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,

  // Permutation in progress
  output logic        busy_o
);

  state_t state;
  logic   busy;
  logic   ack;

  keccak_reg_if reg_if ();

  ////////////////////////////////////////
  // Bus decode
  ////////////////////////////////////////
  keccak_decode u_decode (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_ack_i (ack),
    .reg_o    (reg_if.decode)
  );

  // Permutation core
  keccak_engine u_engine (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .reg_i    (reg_if.engine),
    .state_o  (state),
    .busy_o   (busy)
  );

  // Read side and ack
  keccak_readback u_readback (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_adr_i (wb_adr_i),
    .state_i  (state),
    .busy_i   (busy),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (ack)
  );

  assign wb_ack_o = ack;
  assign busy_o   = busy;

endmodule

`default_nettype wire

/* sources.f */
+incdir+bench
logic/keccak_pkg.sv
logic/keccak_reg_if.sv
logic/keccak_decode.sv
logic/keccak_round.sv
logic/keccak_engine.sv
logic/keccak_readback.sv
logic/keccak_wb_top.sv
bench/keccak_clk_gen.sv
bench/keccak_tb.sv
